/* sim/sdram_patterns.hex */
// op bank row col mask data; op bit0 is write, bit1 sends without an idle gap
// mask bit set keeps that byte lane; data is write data, or the expected word on a read
1 0 05 03 0 a5c3
0 0 05 03 0 a5c3
1 0 05 03 2 1177
0 0 05 03 0 a577
1 0 12 03 0 3c3c
0 0 05 03 0 a577
0 0 12 03 0 3c3c
1 2 05 03 0 beef
0 0 05 03 0 a577
0 2 05 03 0 beef
3 1 20 00 0 1001
3 1 20 01 0 2002
3 1 20 02 0 3003
2 1 20 00 0 1001
3 1 20 02 1 55aa
2 1 20 01 0 2002
2 1 20 02 0 5503
2 0 12 03 0 3c3c

/* sim.f */
+incdir+hw
hw/sdram_dev_pkg.sv
hw/host_req_pkg.sv
hw/host_port.sv
hw/req_queue.sv
hw/sdram_sequencer.sv
hw/sdram_model.sv
hw/sdram_subsys.sv
sim/tb_sdram_subsys.sv

/* Bender.yml */
package:
  name: sdram_subsys

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/sdram_dev_pkg.sv
      - hw/host_req_pkg.sv
      - hw/host_port.sv
      - hw/req_queue.sv
      - hw/sdram_sequencer.sv
      - hw/sdram_model.sv
      - hw/sdram_subsys.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/tb_sdram_subsys.sv

/* sim/tb_sdram_subsys.sv */
/*
 * Testbench for the SDRAM access path. Replays requests from the pattern
 * file, mirrors writes in a reference memory and checks every read word.
 */
`timescale 1ns/1ps
`include "sdram_defs.svh"

module tb_sdram_subsys;
    localparam int NUM_PAT = 18;
    localparam int FIELDS  = 6;     // op bank row col mask data
    localparam int IDX_W   = `SDRAM_BANK_W + `SDRAM_ROW_W + `SDRAM_COL_W;

    logic                       clk;
    logic                       cke;
    logic                       req_valid;
    host_req_pkg::req_op_e      req_op;
    logic [`SDRAM_BANK_W-1:0]   req_bank;
    logic [`SDRAM_ROW_W-1:0]    req_row;
    logic [`SDRAM_COL_W-1:0]    req_col;
    logic [`SDRAM_DATA_W/8-1:0] req_mask;
    logic [`SDRAM_DATA_W-1:0]   req_wdata;
    logic                       req_ready;
    logic                       rd_valid;
    logic [`SDRAM_DATA_W-1:0]   rd_data;

    logic [15:0]                pat_mem [NUM_PAT*FIELDS];
    logic [`SDRAM_DATA_W-1:0]   ref_mem [1 << IDX_W];
    logic [`SDRAM_DATA_W-1:0]   exp_q [$];
    logic [`SDRAM_DATA_W-1:0]   exp_word;
    integer                     seed;
    logic                       ready_dropped;

    sdram_subsys uut (
        .clk         (clk),
        .cke         (cke),
        .req_valid_i (req_valid),
        .req_op_i    (req_op),
        .req_bank_i  (req_bank),
        .req_row_i   (req_row),
        .req_col_i   (req_col),
        .req_mask_i  (req_mask),
        .req_wdata_i (req_wdata),
        .req_ready_o (req_ready),
        .rd_valid_o  (rd_valid),
        .rd_data_o   (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
            abort_run($sformatf("Fail %s: got %h, expected %h", name, actual, expected));
    endtask

    // presents one pattern line until the port takes it
    task automatic send_request(input int n);
        logic [15:0]      op_w;
        logic [15:0]      mask_w;
        logic [15:0]      data_w;
        logic [IDX_W-1:0] idx;
        int               gap;
        op_w   = pat_mem[n*FIELDS];
        mask_w = pat_mem[n*FIELDS+4];
        data_w = pat_mem[n*FIELDS+5];
        if (!op_w[1]) begin
            gap       = $unsigned($random(seed)) % 3;
            req_valid = 1'b0;
            repeat (gap) @(negedge clk);
        end
        req_valid = 1'b1;
        req_op    = host_req_pkg::req_op_e'(op_w[0]);
        req_bank  = pat_mem[n*FIELDS+1][`SDRAM_BANK_W-1:0];
        req_row   = pat_mem[n*FIELDS+2][`SDRAM_ROW_W-1:0];
        req_col   = pat_mem[n*FIELDS+3][`SDRAM_COL_W-1:0];
        req_mask  = mask_w[`SDRAM_DATA_W/8-1:0];
        req_wdata = data_w;
        while (!req_ready) begin
            if (op_w[1])
                ready_dropped = 1'b1;
            @(negedge clk);
        end
        // request transfers on the next rising edge
        idx = {req_bank, req_row, req_col};
        if (op_w[0]) begin
            for (int l = 0; l < `SDRAM_DATA_W/8; l++) begin
                if (!req_mask[l])
                    ref_mem[idx][l*8 +: 8] = data_w[l*8 +: 8];
            end
        end else begin
            check_value("pattern expected word", data_w, ref_mem[idx]);
            exp_q.push_back(data_w);
        end
        @(negedge clk);
    endtask

    // read return monitor on the falling edge
    always @(negedge clk) begin
        if (rd_valid) begin
            if (exp_q.size() == 0) begin
                abort_run("rd_valid_o went high with no read outstanding");
            end else begin
                exp_word = exp_q.pop_front();
                check_value("rd_data_o", rd_data, exp_word);
            end
        end
    end

    initial begin
        repeat (NUM_PAT*40 + 100) @(posedge clk);
        abort_run("watchdog expired before all reads came back");
    end

    initial begin
        seed          = 32'h63d0_e7d0;
        cke           = 1'b0;
        req_valid     = 1'b0;
        req_op        = host_req_pkg::REQ_READ;
        req_bank      = '0;
        req_row       = '0;
        req_col       = '0;
        req_mask      = '0;
        req_wdata     = '0;
        ready_dropped = 1'b0;
        $readmemh("sim/sdram_patterns.hex", pat_mem);
        if ($isunknown(pat_mem[NUM_PAT*FIELDS-1]))
            abort_run("pattern file is missing or shorter than expected");

        repeat (2) begin
            @(negedge clk);
            check_value("rd_valid_o", rd_valid, 1'b0);
            check_value("req_ready_o", req_ready, 1'b1);
        end
        cke = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_value("rd_valid_o", rd_valid, 1'b0);
            check_value("req_ready_o", req_ready, 1'b1);
        end

        for (int n = 0; n < NUM_PAT; n++)
            send_request(n);
        req_valid = 1'b0;

        while (exp_q.size() != 0)
            @(negedge clk);
        repeat (`SDRAM_CAS_LAT + 4) @(negedge clk);   // catch stray returns
        if (!ready_dropped) begin
            abort_run("req_ready_o never dropped during the back-to-back requests");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

/* hw/sdram_subsys.sv */
/*
 * SDRAM access path top level. Host port, request queue and sequencer
 * in a chain, with the device model under the sequencer.
 */
`timescale 1ns/1ps
`include "sdram_defs.svh"

module sdram_subsys (
    input  logic                        clk,
    input  logic                        cke,
    input  logic                        req_valid_i,
    input  host_req_pkg::req_op_e       req_op_i,
    input  logic [`SDRAM_BANK_W-1:0]    req_bank_i,
    input  logic [`SDRAM_ROW_W-1:0]     req_row_i,
    input  logic [`SDRAM_COL_W-1:0]     req_col_i,
    input  logic [`SDRAM_DATA_W/8-1:0]  req_mask_i,
    input  logic [`SDRAM_DATA_W-1:0]    req_wdata_i,
    output logic                        req_ready_o,
    output logic                        rd_valid_o,
    output logic [`SDRAM_DATA_W-1:0]    rd_data_o
);
    // host port to queue
    logic                        q_push;
    logic                        q_credit;
    host_req_pkg::req_op_e       in_op;
    logic [`SDRAM_BANK_W-1:0]    in_bank;
    logic [`SDRAM_ROW_W-1:0]     in_row;
    logic [`SDRAM_COL_W-1:0]     in_col;
    logic [`SDRAM_DATA_W/8-1:0]  in_mask;
    logic [`SDRAM_DATA_W-1:0]    in_wdata;

    // queue head to sequencer
    logic                        q_pop;
    logic                        q_empty;
    host_req_pkg::req_op_e       hd_op;
    logic [`SDRAM_BANK_W-1:0]    hd_bank;
    logic [`SDRAM_ROW_W-1:0]     hd_row;
    logic [`SDRAM_COL_W-1:0]     hd_col;
    logic [`SDRAM_DATA_W/8-1:0]  hd_mask;
    logic [`SDRAM_DATA_W-1:0]    hd_wdata;

    // device bus
    sdram_dev_pkg::sdram_cmd_e   dev_cmd;
    logic [`SDRAM_BANK_W-1:0]    dev_ba;
    sdram_dev_pkg::sdram_addr_u  dev_addr;
    logic [`SDRAM_DATA_W/8-1:0]  dev_dqm;
    logic [`SDRAM_DATA_W-1:0]    dev_wdata;
    logic [`SDRAM_DATA_W-1:0]    dev_rdata;

    host_port u_host_port (
        .clk, .cke, .req_valid_i, .req_op_i, .req_bank_i, .req_row_i,
        .req_col_i, .req_mask_i, .req_wdata_i, .req_ready_o,
        .q_push_o (q_push),  .q_op_o   (in_op),   .q_bank_o  (in_bank),
        .q_row_o  (in_row),  .q_col_o  (in_col),  .q_mask_o  (in_mask),
        .q_wdata_o(in_wdata), .q_credit_i(q_credit)
    );

    req_queue u_req_queue (
        .clk, .cke,
        .push_i (q_push),  .op_i   (in_op),   .bank_i (in_bank), .row_i  (in_row),
        .col_i  (in_col),  .mask_i (in_mask), .wdata_i(in_wdata), .pop_i  (q_pop),
        .op_o   (hd_op),   .bank_o (hd_bank), .row_o  (hd_row),  .col_o  (hd_col),
        .mask_o (hd_mask), .wdata_o(hd_wdata), .empty_o(q_empty), .credit_o(q_credit)
    );

    sdram_sequencer u_sequencer (
        .clk, .cke,
        .q_op_i  (hd_op),   .q_bank_i(hd_bank), .q_row_i  (hd_row), .q_col_i(hd_col),
        .q_mask_i(hd_mask), .q_wdata_i(hd_wdata), .q_empty_i(q_empty), .q_pop_o(q_pop),
        .dev_cmd_o(dev_cmd), .dev_ba_o(dev_ba), .dev_addr_o(dev_addr),
        .dev_dqm_o(dev_dqm), .dev_wdata_o(dev_wdata), .dev_rdata_i(dev_rdata),
        .rd_valid_o, .rd_data_o
    );

    sdram_model u_model (
        .clk, .cke,
        .cmd_i(dev_cmd), .ba_i(dev_ba), .addr_i(dev_addr), .dqm_i(dev_dqm),
        .wdata_i(dev_wdata), .rdata_o(dev_rdata)
    );

endmodule

/* hw/sdram_model.sv */
/*
 * Behavioral model of a 4-bank x16 SDRAM. Decodes commands, keeps the
 * mode register and one open row per bank, and returns read data after
 * the programmed CAS latency on a separate output bus.
 */
`timescale 1ns/1ps
`include "sdram_defs.svh"

module sdram_model (
    input  logic                        clk,
    input  logic                        cke,
    input  sdram_dev_pkg::sdram_cmd_e   cmd_i,
    input  logic [`SDRAM_BANK_W-1:0]    ba_i,
    input  sdram_dev_pkg::sdram_addr_u  addr_i,
    input  logic [`SDRAM_DATA_W/8-1:0]  dqm_i,
    input  logic [`SDRAM_DATA_W-1:0]    wdata_i,
    output logic [`SDRAM_DATA_W-1:0]    rdata_o
);
    localparam int BANKS   = 1 << `SDRAM_BANK_W;
    localparam int IDX_W   = `SDRAM_BANK_W + `SDRAM_ROW_W + `SDRAM_COL_W;
    localparam int LANES   = `SDRAM_DATA_W / 8;
    localparam int MAX_LAT = 3;

    logic [2:0]                cas_lat_q;
    logic [2:0]                burst_len_q;
    logic [`SDRAM_ROW_W-1:0]   open_row [BANKS];
    logic [`SDRAM_DATA_W-1:0]  mem [1 << IDX_W];
    logic [`SDRAM_DATA_W-1:0]  rd_pipe [MAX_LAT];
    logic [IDX_W-1:0]          acc_idx;
    logic                      single_beat;
    logic                      rd_ok;
    logic                      wr_ok;

    // bursts are not modeled, only the one-word setting moves data
    assign single_beat = (burst_len_q == 3'd0);
    assign rd_ok       = (cmd_i == sdram_dev_pkg::READ) && single_beat;
    assign wr_ok       = (cmd_i == sdram_dev_pkg::WRITE) && single_beat;
    assign acc_idx     = {ba_i, open_row[ba_i], addr_i.column.col};

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            cas_lat_q   <= 3'(`SDRAM_CAS_LAT);
            burst_len_q <= 3'd0;
        end else if (cmd_i == sdram_dev_pkg::LOAD_MODE) begin
            cas_lat_q   <= addr_i.mode.cas_lat;
            burst_len_q <= addr_i.mode.burst_len;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_i == sdram_dev_pkg::ACTIVE)
            open_row[ba_i] <= addr_i[`SDRAM_ROW_W-1:0];  // plain word carries the row
    end

    // dqm high masks a byte lane
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            for (int l = 0; l < LANES; l++) begin
                if (!dqm_i[l])
                    mem[acc_idx][l*8 +: 8] <= wdata_i[l*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_pipe[0] <= rd_ok ? mem[acc_idx] : '0;
        for (int i = 1; i < MAX_LAT; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    // tap the pipe at the latched latency
    always_comb begin
        case (cas_lat_q)
            3'd1:    rdata_o = rd_pipe[0];
            3'd3:    rdata_o = rd_pipe[2];
            default: rdata_o = rd_pipe[1];
        endcase
    end

endmodule

/* hw/sdram_sequencer.sv */
/*
 * Command sequencer. Programs the mode register once, then turns each
 * queued request into Activate (on a row miss) and Read or Write, and
 * hands read data back to the host in request order.
 */
`timescale 1ns/1ps
`include "sdram_defs.svh"

module sdram_sequencer (
    input  logic                        clk,
    input  logic                        cke,
    input  host_req_pkg::req_op_e       q_op_i,
    input  logic [`SDRAM_BANK_W-1:0]    q_bank_i,
    input  logic [`SDRAM_ROW_W-1:0]     q_row_i,
    input  logic [`SDRAM_COL_W-1:0]     q_col_i,
    input  logic [`SDRAM_DATA_W/8-1:0]  q_mask_i,
    input  logic [`SDRAM_DATA_W-1:0]    q_wdata_i,
    input  logic                        q_empty_i,
    output logic                        q_pop_o,
    output sdram_dev_pkg::sdram_cmd_e   dev_cmd_o,
    output logic [`SDRAM_BANK_W-1:0]    dev_ba_o,
    output sdram_dev_pkg::sdram_addr_u  dev_addr_o,
    output logic [`SDRAM_DATA_W/8-1:0]  dev_dqm_o,
    output logic [`SDRAM_DATA_W-1:0]    dev_wdata_o,
    input  logic [`SDRAM_DATA_W-1:0]    dev_rdata_i,
    output logic                        rd_valid_o,
    output logic [`SDRAM_DATA_W-1:0]    rd_data_o
);
    localparam int BANKS = 1 << `SDRAM_BANK_W;
    localparam int LAT   = `SDRAM_CAS_LAT;

    localparam logic [1:0] ST_INIT     = 2'd0;
    localparam logic [1:0] ST_IDLE     = 2'd1;
    localparam logic [1:0] ST_ACTIVATE = 2'd2;
    localparam logic [1:0] ST_ACCESS   = 2'd3;

    logic [1:0]                 state_q;
    host_req_pkg::req_op_e      op_q;
    logic [`SDRAM_BANK_W-1:0]   bank_q;
    logic [`SDRAM_COL_W-1:0]    col_q;
    logic [`SDRAM_DATA_W/8-1:0] mask_q;
    logic [`SDRAM_DATA_W-1:0]   wdata_q;
    logic [`SDRAM_ROW_W-1:0]    open_row_q [BANKS];
    logic [BANKS-1:0]           row_valid_q;
    logic [LAT-1:0]             pend_q;     // one bit per cycle of CAS latency

    logic                       row_hit;
    logic                       issue_access;
    host_req_pkg::req_op_e      cur_op;
    logic [`SDRAM_BANK_W-1:0]   cur_bank;
    logic [`SDRAM_COL_W-1:0]    cur_col;
    logic [`SDRAM_DATA_W/8-1:0] cur_mask;
    logic [`SDRAM_DATA_W-1:0]   cur_wdata;
    sdram_dev_pkg::sdram_cmd_e  access_cmd;
    sdram_dev_pkg::sdram_addr_u mode_word;
    sdram_dev_pkg::sdram_addr_u col_word;

    assign q_pop_o      = (state_q == ST_IDLE) && !q_empty_i;
    assign row_hit      = row_valid_q[q_bank_i] && (open_row_q[q_bank_i] == q_row_i);
    assign issue_access = (q_pop_o && row_hit) || (state_q == ST_ACTIVATE);

    // head entry on a hit, latched entry after an activate
    always_comb begin
        if (state_q == ST_IDLE) begin
            cur_op    = q_op_i;
            cur_bank  = q_bank_i;
            cur_col   = q_col_i;
            cur_mask  = q_mask_i;
            cur_wdata = q_wdata_i;
        end else begin
            cur_op    = op_q;
            cur_bank  = bank_q;
            cur_col   = col_q;
            cur_mask  = mask_q;
            cur_wdata = wdata_q;
        end
        access_cmd = (cur_op == host_req_pkg::REQ_WRITE) ? sdram_dev_pkg::WRITE
                                                          : sdram_dev_pkg::READ;
        mode_word                 = '0;
        mode_word.mode.cas_lat    = 3'(LAT);
        mode_word.mode.burst_type = 1'b0;
        mode_word.mode.burst_len  = 3'd0;   // single word
        col_word                  = '0;
        col_word.column.col       = cur_col;
    end

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            state_q     <= ST_INIT;
            dev_cmd_o   <= sdram_dev_pkg::NOP;
            row_valid_q <= '0;
        end else begin
            case (state_q)
                ST_INIT: begin
                    dev_cmd_o <= sdram_dev_pkg::LOAD_MODE;
                    state_q   <= ST_IDLE;
                end
                ST_IDLE: begin
                    if (q_pop_o && row_hit) begin
                        dev_cmd_o <= access_cmd;
                        state_q   <= ST_ACCESS;
                    end else if (q_pop_o) begin
                        dev_cmd_o             <= sdram_dev_pkg::ACTIVE;
                        state_q               <= ST_ACTIVATE;
                        row_valid_q[q_bank_i] <= 1'b1;
                    end else begin
                        dev_cmd_o <= sdram_dev_pkg::NOP;
                    end
                end
                ST_ACTIVATE: begin
                    dev_cmd_o <= access_cmd;
                    state_q   <= ST_ACCESS;
                end
                default: begin  // access command is on the bus
                    dev_cmd_o <= sdram_dev_pkg::NOP;
                    state_q   <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (q_pop_o) begin
            op_q    <= q_op_i;
            bank_q  <= q_bank_i;
            col_q   <= q_col_i;
            mask_q  <= q_mask_i;
            wdata_q <= q_wdata_i;
        end
        if (q_pop_o && !row_hit)
            open_row_q[q_bank_i] <= q_row_i;

        if (state_q == ST_INIT) begin
            dev_ba_o   <= '0;
            dev_addr_o <= mode_word;
            dev_dqm_o  <= '0;
        end else if (issue_access) begin
            dev_ba_o    <= cur_bank;
            dev_addr_o  <= col_word;
            dev_dqm_o   <= (cur_op == host_req_pkg::REQ_WRITE) ? cur_mask : '0;
            dev_wdata_o <= cur_wdata;
        end else if (q_pop_o) begin
            dev_ba_o   <= q_bank_i;
            dev_addr_o <= {{(`SDRAM_ADDR_W-`SDRAM_ROW_W){1'b0}}, q_row_i};  // row for activate
        end
    end

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            pend_q     <= '0;
            rd_valid_o <= 1'b0;
        end else begin
            pend_q     <= (pend_q << 1) | LAT'(dev_cmd_o == sdram_dev_pkg::READ);
            rd_valid_o <= pend_q[LAT-1];
        end
    end

    always_ff @(posedge clk) begin
        if (pend_q[LAT-1])
            rd_data_o <= dev_rdata_i;
    end

endmodule

/* hw/req_queue.sv */
/*
 * Request FIFO between host port and sequencer. Presents the head entry
 * and returns one registered credit pulse per pop.
 */
`timescale 1ns/1ps
`include "sdram_defs.svh"

module req_queue (
    input  logic                        clk,
    input  logic                        cke,
    input  logic                        push_i,
    input  host_req_pkg::req_op_e       op_i,
    input  logic [`SDRAM_BANK_W-1:0]    bank_i,
    input  logic [`SDRAM_ROW_W-1:0]     row_i,
    input  logic [`SDRAM_COL_W-1:0]     col_i,
    input  logic [`SDRAM_DATA_W/8-1:0]  mask_i,
    input  logic [`SDRAM_DATA_W-1:0]    wdata_i,
    input  logic                        pop_i,
    output host_req_pkg::req_op_e       op_o,
    output logic [`SDRAM_BANK_W-1:0]    bank_o,
    output logic [`SDRAM_ROW_W-1:0]     row_o,
    output logic [`SDRAM_COL_W-1:0]     col_o,
    output logic [`SDRAM_DATA_W/8-1:0]  mask_o,
    output logic [`SDRAM_DATA_W-1:0]    wdata_o,
    output logic                        empty_o,
    output logic                        credit_o
);
    localparam int PTR_W   = $clog2(`REQ_QUEUE_DEPTH);
    localparam int ENTRY_W = 1 + `SDRAM_BANK_W + `SDRAM_ROW_W + `SDRAM_COL_W
                           + `SDRAM_DATA_W/8 + `SDRAM_DATA_W;

    logic [ENTRY_W-1:0] mem [`REQ_QUEUE_DEPTH];
    logic [ENTRY_W-1:0] head;
    logic [PTR_W:0]     wr_ptr_q;   // extra bit tells wrap
    logic [PTR_W:0]     rd_ptr_q;

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop_i)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            credit_o <= pop_i;
        end
    end

    always_ff @(posedge clk) begin
        if (push_i)
            mem[wr_ptr_q[PTR_W-1:0]] <= {op_i, bank_i, row_i, col_i, mask_i, wdata_i};
    end

    assign empty_o = (rd_ptr_q == wr_ptr_q);
    assign head    = mem[rd_ptr_q[PTR_W-1:0]];
    assign op_o    = host_req_pkg::req_op_e'(head[ENTRY_W-1]);
    assign {bank_o, row_o, col_o, mask_o, wdata_o} = head[ENTRY_W-2:0];

endmodule

/* hw/host_port.sv */
/*
 * Host request port. Admits requests while credits remain and pushes
 * each accepted request into the queue one cycle later.
 */
`timescale 1ns/1ps
`include "sdram_defs.svh"

module host_port (
    input  logic                        clk,
    input  logic                        cke,
    input  logic                        req_valid_i,
    input  host_req_pkg::req_op_e       req_op_i,
    input  logic [`SDRAM_BANK_W-1:0]    req_bank_i,
    input  logic [`SDRAM_ROW_W-1:0]     req_row_i,
    input  logic [`SDRAM_COL_W-1:0]     req_col_i,
    input  logic [`SDRAM_DATA_W/8-1:0]  req_mask_i,
    input  logic [`SDRAM_DATA_W-1:0]    req_wdata_i,
    output logic                        req_ready_o,
    output logic                        q_push_o,
    output host_req_pkg::req_op_e       q_op_o,
    output logic [`SDRAM_BANK_W-1:0]    q_bank_o,
    output logic [`SDRAM_ROW_W-1:0]     q_row_o,
    output logic [`SDRAM_COL_W-1:0]     q_col_o,
    output logic [`SDRAM_DATA_W/8-1:0]  q_mask_o,
    output logic [`SDRAM_DATA_W-1:0]    q_wdata_o,
    input  logic                        q_credit_i
);
    localparam int CRED_W = $clog2(`REQ_QUEUE_DEPTH + 1);

    logic [CRED_W-1:0] credit_q;
    logic              accept;

    assign req_ready_o = (credit_q != '0);
    assign accept      = req_valid_i && req_ready_o;

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            credit_q <= CRED_W'(`REQ_QUEUE_DEPTH);
            q_push_o <= 1'b0;
        end else begin
            q_push_o <= accept;
            case ({accept, q_credit_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;  // none, or both cancel
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            q_op_o    <= req_op_i;
            q_bank_o  <= req_bank_i;
            q_row_o   <= req_row_i;
            q_col_o   <= req_col_i;
            q_mask_o  <= req_mask_i;
            q_wdata_o <= req_wdata_i;
        end
    end

endmodule

/* hw/host_req_pkg.sv */
/*
 * Host-side request types, used from the host port through the queue
 * to the sequencer.
 */
package host_req_pkg;

    typedef enum logic {
        REQ_READ  = 1'b0,
        REQ_WRITE = 1'b1
    } req_op_e;

endpackage

/* hw/sdram_dev_pkg.sv */
/*
 * Device-side types shared by the sequencer and the SDRAM model.
 * The address word is a union with a mode view and a column view.
 */
`include "sdram_defs.svh"

package sdram_dev_pkg;

    typedef enum logic [2:0] {
        NOP       = 3'd0,
        ACTIVE    = 3'd1,
        READ      = 3'd2,
        WRITE     = 3'd3,
        LOAD_MODE = 3'd4
    } sdram_cmd_e;

    // one address word, decoded per command
    typedef union packed {
        struct packed {
            logic [`SDRAM_ADDR_W-8:0] reserved;   // bits 12:7
            logic [2:0]               cas_lat;
            logic                     burst_type; // 0 sequential
            logic [2:0]               burst_len;  // 0 is one word
        } mode;
        struct packed {
            logic [`SDRAM_ADDR_W-`SDRAM_COL_W-1:0] unused;
            logic [`SDRAM_COL_W-1:0]               col;
        } column;
    } sdram_addr_u;

endpackage

/* hw/sdram_defs.svh */
/*
 * Widths, queue depth and CAS latency for the SDRAM access path.
 * Included by the packages and RTL modules that size ports or storage.
 */
`ifndef SDRAM_DEFS_SVH
`define SDRAM_DEFS_SVH

// address fields, kept small so the model's storage simulates quickly
`define SDRAM_BANK_W 2
`define SDRAM_ROW_W 6
`define SDRAM_COL_W 5

// device data word and address bus
`define SDRAM_DATA_W 16
`define SDRAM_ADDR_W 13

// CAS latency programmed at Load Mode, 2 or 3
`define SDRAM_CAS_LAT 2

// queue entries, equal to the number of host credits
`define REQ_QUEUE_DEPTH 4

`endif
